/* logic/l2_localmem.sv */
/* l2_localmem: L2 local storage top with write controller, per-way
   stores and the eviction-way RAM */
`timescale 1ns/10ps

module l2_localmem (
    input  logic            clk,
    input  logic            wr_rst,
    input  logic            rd_en,
    input  logic            wr_en_line,
    input  logic            wr_en_state,
    input  logic            wr_en_put_reqs,
    input  logic            wr_en_all_ways,
    input  logic            wr_en_evict_way,
    input  l2_pkg::l2_set_t set_in,
    input  l2_pkg::l2_way_t way,
    input  l2_pkg::line_t   wr_data_line,
    input  l2_pkg::l2_tag_t wr_data_tag,
    input  l2_pkg::hprot_t  wr_data_hprot,
    input  l2_pkg::state_t  wr_data_state,
    input  l2_pkg::l2_way_t wr_data_evict_way,
    output logic            ready,
    output l2_pkg::line_t   rd_data_line [l2_pkg::L2_WAYS],
    output l2_pkg::l2_tag_t rd_data_tag [l2_pkg::L2_WAYS],
    output l2_pkg::state_t  rd_data_state [l2_pkg::L2_WAYS],
    output l2_pkg::hprot_t  rd_data_hprot [l2_pkg::L2_WAYS],
    output l2_pkg::l2_way_t rd_data_evict_way
);

    import l2_pkg::*;

    l2_set_t addr;
    state_t  state_data;
    l2_way_t evict_data;
    logic    we_line [L2_WAYS];
    logic    we_tag [L2_WAYS];
    logic    we_state [L2_WAYS];
    logic    we_hprot [L2_WAYS];
    logic    we_evict;

    l2_write_ctrl write_ctrl_i (
        .clk               (clk),
        .wr_rst            (wr_rst),
        .set_in            (set_in),
        .way               (way),
        .wr_en_line        (wr_en_line),
        .wr_en_state       (wr_en_state),
        .wr_en_put_reqs    (wr_en_put_reqs),
        .wr_en_all_ways    (wr_en_all_ways),
        .wr_en_evict_way   (wr_en_evict_way),
        .wr_data_state     (wr_data_state),
        .wr_data_evict_way (wr_data_evict_way),
        .ready             (ready),
        .addr              (addr),
        .state_data        (state_data),
        .evict_data        (evict_data),
        .we_line           (we_line),
        .we_tag            (we_tag),
        .we_state          (we_state),
        .we_hprot          (we_hprot),
        .we_evict          (we_evict)
    );

    // all ways share address and data and differ only in their enables
    for (genvar w = 0; w < L2_WAYS; w++) begin : g_way
        l2_way_store way_store_i (
            .clk (clk), .wr_rst (wr_rst), .rd_en (rd_en), .addr (addr),
            .we_line (we_line[w]), .we_tag (we_tag[w]),
            .we_state (we_state[w]), .we_hprot (we_hprot[w]),
            .wr_data_line (wr_data_line), .wr_data_tag (wr_data_tag),
            .wr_data_state (state_data), .wr_data_hprot (wr_data_hprot),
            .rd_data_line (rd_data_line[w]), .rd_data_tag (rd_data_tag[w]),
            .rd_data_state (rd_data_state[w]), .rd_data_hprot (rd_data_hprot[w])
        );
    end

    l2_sram #(.DATA_BITS(L2_WAY_BITS), .ADDR_BITS(L2_SET_BITS)) evict_way_ram (
        .clk     (clk),
        .wr_rst  (wr_rst),
        .rd_en   (rd_en),
        .we      (we_evict),
        .addr    (addr),
        .wr_data (evict_data),
        .rd_data (rd_data_evict_way)
    );

endmodule

/* logic/l2_pkg.sv */
/* l2_pkg: cache geometry constants, field vector types and the
   state type of the init sweep machine */
package l2_pkg;

    // geometry
    localparam int L2_WAYS = 4;
    localparam int L2_WAY_BITS = 2;
    localparam int L2_SET_BITS = 6;
    localparam int L2_SETS = 64;

    // field widths
    localparam int L2_TAG_BITS = 12;
    localparam int L2_LINE_BITS = 128;
    localparam int L2_STATE_BITS = 3;
    localparam int L2_HPROT_BITS = 1;

    // coherence state written into every way by the init sweep
    localparam int L2_STATE_INVALID = 0;

    // set index
    typedef logic [L2_SET_BITS-1:0] l2_set_t;

    // way index, also the eviction-way entry
    typedef logic [L2_WAY_BITS-1:0] l2_way_t;

    typedef logic [L2_TAG_BITS-1:0] l2_tag_t;

    // four 32-bit words
    typedef logic [L2_LINE_BITS-1:0] line_t;

    typedef logic [L2_STATE_BITS-1:0] state_t;

    typedef logic [L2_HPROT_BITS-1:0] hprot_t;

    // init sweep machine
    typedef enum logic {
        INIT_SWEEP,
        INIT_READY
    } init_st_t;

endpackage

/* logic/l2_sram.sv */
/* l2_sram: single-port synchronous RAM, read-first, with read enable
   and a cleared output register */
`timescale 1ns/10ps

module l2_sram #(
    parameter int DATA_BITS = 8,
    parameter int ADDR_BITS = 6
) (
    input  logic                 clk,
    input  logic                 wr_rst,
    input  logic                 rd_en,
    input  logic                 we,
    input  logic [ADDR_BITS-1:0] addr,
    input  logic [DATA_BITS-1:0] wr_data,
    output logic [DATA_BITS-1:0] rd_data
);

    logic [DATA_BITS-1:0] mem [2**ADDR_BITS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wr_data;
        end
    end

    // old contents are returned when read and write hit the same entry
    always_ff @(posedge clk) begin
        if (wr_rst) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[addr];
        end
    end

endmodule

/* logic/l2_way_store.sv */
/* l2_way_store: line, tag, state and hprot arrays of one cache way,
   read together for the addressed set */
`timescale 1ns/10ps

module l2_way_store (
    input  logic            clk,
    input  logic            wr_rst,
    input  logic            rd_en,
    input  l2_pkg::l2_set_t addr,
    input  logic            we_line,
    input  logic            we_tag,
    input  logic            we_state,
    input  logic            we_hprot,
    input  l2_pkg::line_t   wr_data_line,
    input  l2_pkg::l2_tag_t wr_data_tag,
    input  l2_pkg::state_t  wr_data_state,
    input  l2_pkg::hprot_t  wr_data_hprot,
    output l2_pkg::line_t   rd_data_line,
    output l2_pkg::l2_tag_t rd_data_tag,
    output l2_pkg::state_t  rd_data_state,
    output l2_pkg::hprot_t  rd_data_hprot
);

    import l2_pkg::*;

    l2_sram #(.DATA_BITS(L2_LINE_BITS), .ADDR_BITS(L2_SET_BITS)) line_ram (
        .clk     (clk),
        .wr_rst  (wr_rst),
        .rd_en   (rd_en),
        .we      (we_line),
        .addr    (addr),
        .wr_data (wr_data_line),
        .rd_data (rd_data_line)
    );

    l2_sram #(.DATA_BITS(L2_TAG_BITS), .ADDR_BITS(L2_SET_BITS)) tag_ram (
        .clk     (clk),
        .wr_rst  (wr_rst),
        .rd_en   (rd_en),
        .we      (we_tag),
        .addr    (addr),
        .wr_data (wr_data_tag),
        .rd_data (rd_data_tag)
    );

    // written by the init sweep as well as by host commands
    l2_sram #(.DATA_BITS(L2_STATE_BITS), .ADDR_BITS(L2_SET_BITS)) state_ram (
        .clk     (clk),
        .wr_rst  (wr_rst),
        .rd_en   (rd_en),
        .we      (we_state),
        .addr    (addr),
        .wr_data (wr_data_state),
        .rd_data (rd_data_state)
    );

    l2_sram #(.DATA_BITS(L2_HPROT_BITS), .ADDR_BITS(L2_SET_BITS)) hprot_ram (
        .clk     (clk),
        .wr_rst  (wr_rst),
        .rd_en   (rd_en),
        .we      (we_hprot),
        .addr    (addr),
        .wr_data (wr_data_hprot),
        .rd_data (rd_data_hprot)
    );

endmodule

/* logic/l2_write_ctrl.sv */
/* l2_write_ctrl: init sweep FSM with ready output, way decode and
   selection of write enables, address and write data */
`timescale 1ns/10ps

module l2_write_ctrl (
    input  logic            clk,
    input  logic            wr_rst,
    input  l2_pkg::l2_set_t set_in,
    input  l2_pkg::l2_way_t way,
    input  logic            wr_en_line,
    input  logic            wr_en_state,
    input  logic            wr_en_put_reqs,
    input  logic            wr_en_all_ways,
    input  logic            wr_en_evict_way,
    input  l2_pkg::state_t  wr_data_state,
    input  l2_pkg::l2_way_t wr_data_evict_way,
    output logic            ready,
    output l2_pkg::l2_set_t addr,
    output l2_pkg::state_t  state_data,
    output l2_pkg::l2_way_t evict_data,
    output logic            we_line [l2_pkg::L2_WAYS],
    output logic            we_tag [l2_pkg::L2_WAYS],
    output logic            we_state [l2_pkg::L2_WAYS],
    output logic            we_hprot [l2_pkg::L2_WAYS],
    output logic            we_evict
);

    import l2_pkg::*;

    init_st_t init_st;
    l2_set_t  sweep_set;

    // one set per cycle, then stay in INIT_READY until the next reset
    always_ff @(posedge clk) begin
        if (wr_rst) begin
            init_st <= INIT_SWEEP;
            sweep_set <= '0;
        end else if (init_st == INIT_SWEEP) begin
            sweep_set <= sweep_set + 1'b1;
            if (sweep_set == l2_set_t'(L2_SETS - 1)) begin
                init_st <= INIT_READY;
            end
        end
    end

    assign ready = (init_st == INIT_READY);

    always_comb begin
        logic way_sel;

        way_sel = 1'b0;
        addr = set_in;
        state_data = wr_data_state;
        evict_data = wr_data_evict_way;
        we_evict = 1'b0;
        for (int i = 0; i < L2_WAYS; i++) begin
            we_line[i] = 1'b0;
            we_tag[i] = 1'b0;
            we_state[i] = 1'b0;
            we_hprot[i] = 1'b0;
        end

        case (init_st)
            INIT_SWEEP: begin
                // invalidate all ways and clear the eviction entry of the swept set
                addr = sweep_set;
                state_data = state_t'(L2_STATE_INVALID);
                evict_data = '0;
                we_evict = 1'b1;
                for (int i = 0; i < L2_WAYS; i++) begin
                    we_state[i] = 1'b1;
                end
            end
            default: begin
                we_evict = wr_en_evict_way;
                for (int i = 0; i < L2_WAYS; i++) begin
                    way_sel = (way == l2_way_t'(i));
                    we_line[i] = way_sel & (wr_en_line | wr_en_put_reqs);
                    we_tag[i] = way_sel & wr_en_put_reqs;
                    we_hprot[i] = way_sel & wr_en_put_reqs;
                    // all-ways state write ignores the way index
                    we_state[i] = (way_sel & (wr_en_state | wr_en_put_reqs)) | wr_en_all_ways;
                end
            end
        endcase
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the L2 local storage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module l2_localmem_tb -Mdir obj_dir \
    || { echo "build failed"; exit 1; }

sim_out="$(./obj_dir/Vl2_localmem_tb)"
echo "$sim_out"

echo "$sim_out" | grep -qx "Done: no errors" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* include/l2_tb_vectors.svh */
/* testbench table: row operations, row layout and the stimulus rows
   with expected state and eviction way for read rows */
`ifndef L2_TB_VECTORS_SVH
`define L2_TB_VECTORS_SVH

// TB_HOLD drops rd_en and moves set_in while the outputs hold
typedef enum logic [2:0] {
    TB_READ, TB_PUT, TB_LINE, TB_STATE, TB_ALL, TB_EVICT, TB_HOLD
} tb_op_t;

// state and evict hold the write data of write rows
// and the expected state of way and eviction way of read and hold rows
typedef struct packed {
    int     beh;
    tb_op_t op;
    int     set;
    int     way;
    int     state;
    int     evict;
} tb_row_t;

localparam int TB_ROWS = 19;

localparam tb_row_t TB_VECTORS [TB_ROWS] = '{
    '{1, TB_READ, 0, 0, 0, 0}, '{1, TB_READ, 32, 3, 0, 0}, '{1, TB_READ, 63, 1, 0, 0},
    '{2, TB_PUT, 5, 2, 3, 0}, '{2, TB_READ, 5, 2, 3, 0}, '{2, TB_READ, 6, 2, 0, 0},
    '{3, TB_LINE, 5, 2, 0, 0}, '{3, TB_READ, 5, 2, 3, 0},
    '{3, TB_STATE, 5, 2, 5, 0}, '{3, TB_READ, 5, 2, 5, 0},
    '{4, TB_PUT, 9, 1, 2, 0}, '{4, TB_ALL, 9, 0, 4, 0}, '{4, TB_READ, 9, 1, 4, 0},
    '{5, TB_EVICT, 10, 0, 0, 3}, '{5, TB_EVICT, 11, 0, 0, 1},
    '{5, TB_READ, 10, 0, 0, 3}, '{5, TB_READ, 11, 0, 0, 1},
    '{6, TB_READ, 5, 2, 5, 0}, '{6, TB_HOLD, 9, 2, 5, 0}
};

`endif

/* testbench/l2_localmem_tb.sv */
/* testbench for the L2 local storage: clock, reset, table-driven commands
   and reads checked against a model of the write rules */
`timescale 1ns/10ps

module l2_localmem_tb;

    import l2_pkg::*;

    `include "l2_tb_vectors.svh"

    localparam int CLK_PERIOD = 20;
    localparam int RST_CYCLES = 5;
    localparam int READY_TIMEOUT = 200;

    logic    clk;
    logic    wr_rst;
    logic    rd_en;
    logic    wr_en_line;
    logic    wr_en_state;
    logic    wr_en_put_reqs;
    logic    wr_en_all_ways;
    logic    wr_en_evict_way;
    l2_set_t set_in;
    l2_way_t way;
    line_t   wr_data_line;
    l2_tag_t wr_data_tag;
    hprot_t  wr_data_hprot;
    state_t  wr_data_state;
    l2_way_t wr_data_evict_way;
    logic    ready;
    line_t   rd_data_line [L2_WAYS];
    l2_tag_t rd_data_tag [L2_WAYS];
    state_t  rd_data_state [L2_WAYS];
    hprot_t  rd_data_hprot [L2_WAYS];
    l2_way_t rd_data_evict_way;

    // model of the storage contents
    // line, tag and hprot of a way are known only after a put
    line_t   m_line [L2_SETS][L2_WAYS];
    l2_tag_t m_tag [L2_SETS][L2_WAYS];
    state_t  m_state [L2_SETS][L2_WAYS];
    hprot_t  m_hprot [L2_SETS][L2_WAYS];
    bit      m_known [L2_SETS][L2_WAYS];
    l2_way_t m_evict [L2_SETS];

    int seed = 87;
    int errors = 0;
    int checks = 0;
    int last_set = 0;
    hprot_t put_hprot = '0;

    l2_localmem l2_localmem_i (
        .clk (clk), .wr_rst (wr_rst), .rd_en (rd_en),
        .wr_en_line (wr_en_line), .wr_en_state (wr_en_state),
        .wr_en_put_reqs (wr_en_put_reqs), .wr_en_all_ways (wr_en_all_ways),
        .wr_en_evict_way (wr_en_evict_way), .set_in (set_in), .way (way),
        .wr_data_line (wr_data_line), .wr_data_tag (wr_data_tag),
        .wr_data_hprot (wr_data_hprot), .wr_data_state (wr_data_state),
        .wr_data_evict_way (wr_data_evict_way), .ready (ready),
        .rd_data_line (rd_data_line), .rd_data_tag (rd_data_tag),
        .rd_data_state (rd_data_state), .rd_data_hprot (rd_data_hprot),
        .rd_data_evict_way (rd_data_evict_way)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic compare_value(input string name, input line_t got, input line_t exp);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic idle_inputs();
        rd_en = 1'b0;
        wr_en_line = 1'b0;
        wr_en_state = 1'b0;
        wr_en_put_reqs = 1'b0;
        wr_en_all_ways = 1'b0;
        wr_en_evict_way = 1'b0;
    endtask

    // the row's way against the table and every way against the model
    task automatic check_set(input int s, input tb_row_t r);
        compare_value("rd_data_state", line_t'(rd_data_state[r.way]), line_t'(r.state));
        compare_value("rd_data_evict_way", line_t'(rd_data_evict_way), line_t'(r.evict));
        compare_value("rd_data_evict_way", line_t'(rd_data_evict_way), line_t'(m_evict[s]));
        for (int w = 0; w < L2_WAYS; w++) begin
            compare_value($sformatf("rd_data_state[%0d]", w), line_t'(rd_data_state[w]),
                line_t'(m_state[s][w]));
            if (m_known[s][w]) begin
                compare_value($sformatf("rd_data_line[%0d]", w), rd_data_line[w],
                    m_line[s][w]);
                compare_value($sformatf("rd_data_tag[%0d]", w), line_t'(rd_data_tag[w]),
                    line_t'(m_tag[s][w]));
                compare_value($sformatf("rd_data_hprot[%0d]", w), line_t'(rd_data_hprot[w]),
                    line_t'(m_hprot[s][w]));
            end
        end
    endtask

    task automatic drive_row(input tb_row_t r);
        idle_inputs();
        set_in = l2_set_t'(r.set);
        way = l2_way_t'(r.way);
        wr_data_state = state_t'(r.state);
        wr_data_evict_way = l2_way_t'(r.evict);
        // new data in every row makes a write by the wrong strobe visible
        wr_data_line = {$random(seed), $random(seed), $random(seed), $random(seed)};
        wr_data_tag = l2_tag_t'($random(seed));
        wr_data_hprot = ~put_hprot;
        case (r.op)
            TB_READ: rd_en = 1'b1;
            TB_PUT: begin
                wr_en_put_reqs = 1'b1;
                wr_data_hprot = hprot_t'($random(seed));
                put_hprot = wr_data_hprot;
                m_line[r.set][r.way] = wr_data_line;
                m_tag[r.set][r.way] = wr_data_tag;
                m_hprot[r.set][r.way] = wr_data_hprot;
                m_state[r.set][r.way] = wr_data_state;
                m_known[r.set][r.way] = 1'b1;
            end
            TB_LINE: begin
                wr_en_line = 1'b1;
                m_line[r.set][r.way] = wr_data_line;
            end
            TB_STATE: begin
                wr_en_state = 1'b1;
                m_state[r.set][r.way] = wr_data_state;
            end
            TB_ALL: begin
                wr_en_all_ways = 1'b1;
                for (int w = 0; w < L2_WAYS; w++) begin
                    m_state[r.set][w] = wr_data_state;
                end
            end
            TB_EVICT: begin
                wr_en_evict_way = 1'b1;
                m_evict[r.set] = wr_data_evict_way;
            end
            default: rd_en = 1'b0;
        endcase
        @(posedge clk);
        #1;
        idle_inputs();
        if (r.op == TB_READ) begin
            check_set(r.set, r);
            last_set = r.set;
        end else if (r.op == TB_HOLD) begin
            // outputs still belong to the last set read
            check_set(last_set, r);
        end
    endtask

    task automatic report_behavior(input int beh, input int beh_errors);
        $display("behavior %0d: %s (%0d errors)", beh, (beh_errors == 0) ? "pass" : "fail",
            beh_errors);
    endtask

    initial begin
        int cycles;
        int cur_beh;
        int beh_start;

        wr_rst = 1'b1;
        idle_inputs();
        set_in = '0;
        way = '0;
        wr_data_line = '0;
        wr_data_tag = '0;
        wr_data_hprot = '0;
        wr_data_state = '0;
        wr_data_evict_way = '0;
        for (int s = 0; s < L2_SETS; s++) begin
            m_evict[s] = '0;
            for (int w = 0; w < L2_WAYS; w++) begin
                m_state[s][w] = state_t'(L2_STATE_INVALID);
                m_known[s][w] = 1'b0;
            end
        end

        repeat (RST_CYCLES) @(posedge clk);
        #1;
        wr_rst = 1'b0;

        // sweep takes one cycle per set
        cycles = 0;
        while (!ready && cycles < READY_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end

        if (!ready) begin
            $display("ready never rose after reset within %0d cycles", READY_TIMEOUT);
            errors++;
        end else begin
            beh_start = 0;
            compare_value("ready latency", line_t'(cycles), line_t'(L2_SETS));
            cur_beh = TB_VECTORS[0].beh;
            for (int r = 0; r < TB_ROWS; r++) begin
                if (TB_VECTORS[r].beh != cur_beh) begin
                    report_behavior(cur_beh, errors - beh_start);
                    cur_beh = TB_VECTORS[r].beh;
                    beh_start = errors;
                end
                drive_row(TB_VECTORS[r]);
            end
            report_behavior(cur_beh, errors - beh_start);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
logic/l2_pkg.sv
logic/l2_sram.sv
logic/l2_way_store.sv
logic/l2_write_ctrl.sv
logic/l2_localmem.sv
testbench/l2_localmem_tb.sv
